/* hw/cpu_pkg.sv */
//////////////////////////////////////////////////////////////////////
// cpu package
// widths, opcodes, control pin fields and shared types for the
// 8-bit accumulator processor
//////////////////////////////////////////////////////////////////////

package cpu_pkg;

  //////////////////////////////////////////////////////////////////////
  // widths and sizes
  //////////////////////////////////////////////////////////////////////

  // one byte of data, register contents and pin values
  typedef logic [7:0] data_t;

  // program memory address
  typedef logic [3:0] addr_t;

  // immediate operand, also the low half of an instruction
  typedef logic [3:0] nibble_t;

  // register select
  typedef logic [1:0] reg_sel_t;

  localparam int MEM_DEPTH = 16;
  localparam int NUM_REGS  = 3;

  localparam reg_sel_t REG_A    = 2'd0;
  localparam reg_sel_t REG_B    = 2'd1;
  localparam reg_sel_t REG_C    = 2'd2;
  // selects no register
  localparam reg_sel_t REG_NONE = 2'd3;

  //////////////////////////////////////////////////////////////////////
  // instruction set
  //////////////////////////////////////////////////////////////////////

  // high nibble of an instruction, codes 12 to 15 behave as NOP
  typedef enum logic [3:0] {
    NOP    = 4'd0,
    LDA_LO = 4'd1,
    LDA_HI = 4'd2,
    LDB_LO = 4'd3,
    LDB_HI = 4'd4,
    LDC_LO = 4'd5,
    LDC_HI = 4'd6,
    ADD    = 4'd7,
    SUB    = 4'd8,
    MUL    = 4'd9,
    OUT    = 4'd10,
    IN     = 4'd11
  } opcode_e;

  typedef enum logic [1:0] {
    ALU_ADD = 2'd0,
    ALU_SUB = 2'd1,
    ALU_MUL = 2'd2
  } alu_op_e;

  // control byte on uio_in: run, mode, memory address
  localparam int RUN_BIT  = 7;
  localparam int MODE_MSB = 5;
  localparam int MODE_LSB = 4;
  localparam int ADDR_MSB = 3;
  localparam int ADDR_LSB = 0;

  localparam logic [1:0] MODE_LOAD = 2'b01;

endpackage

/* hw/cpu_ctrl_if.sv */
//////////////////////////////////////////////////////////////////////
// decoded control bundle
// register, ALU and port enables from the decoder to the datapath
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

interface cpu_ctrl_if
  import cpu_pkg::*;
();

  // nibble loads, one bit per register
  logic [NUM_REGS-1:0] lo_we;
  logic [NUM_REGS-1:0] hi_we;
  nibble_t             imm;

  // arithmetic into C
  logic                alu_we;
  alu_op_e             alu_op;

  // IN capture and OUT register
  logic [NUM_REGS-1:0] in_we;
  logic                out_we;
  reg_sel_t            out_sel;

  modport decoder (
    output lo_we, hi_we, imm, alu_we, alu_op, in_we, out_we, out_sel
  );

  modport datapath (
    input  lo_we, hi_we, imm, alu_we, alu_op, in_we, out_we, out_sel
  );

endinterface

/* hw/program_store.sv */
//////////////////////////////////////////////////////////////////////
// program store
// 16-byte program memory written by the host while stopped, plus
// the program counter and instruction fetch
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module program_store
  import cpu_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  logic  run,
  input  logic  load_we,
  input  addr_t load_addr,
  input  data_t load_data,
  output data_t instr,
  output logic  instr_valid
);

  data_t mem [MEM_DEPTH];
  addr_t pc;

  //////////////////////////////////////////////////////////////////////
  // program memory
  //////////////////////////////////////////////////////////////////////

  // memory starts out cleared, host bytes land at the edge of the strobe
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < MEM_DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if (load_we) begin
      mem[load_addr] <= load_data;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // run sampling and program counter
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      instr_valid <= 1'b0;
    end else begin
      instr_valid <= run;
    end
  end

  // counter sits at 0 while stopped so every run starts at address 0
  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
    end else if (instr_valid) begin
      // 4-bit counter wraps after address 15 on its own
      pc <= pc + 1'b1;
    end else begin
      pc <= '0;
    end
  end

  // fetch is combinational from the current address
  assign instr = mem[pc];

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  // host must stop the processor before writing the program
  a_no_load_while_running : assert property (
    @(posedge clk) disable iff (rst)
      !(load_we && run)
  ) else $error("program_store: load strobe while run is high");

endmodule

/* hw/instruction_decoder.sv */
//////////////////////////////////////////////////////////////////////
// instruction decoder
// splits the fetched byte into opcode and operand and raises the
// matching register, ALU and port enables
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module instruction_decoder
  import cpu_pkg::*;
(
  input  data_t            instr,
  input  logic             instr_valid,
  cpu_ctrl_if.decoder      ctrl
);

  opcode_e opcode;
  nibble_t operand;
  logic    operand_is_reg;

  assign opcode  = opcode_e'(instr[7:4]);
  assign operand = instr[3:0];

  // IN and OUT only act on A, B or C
  assign operand_is_reg = (operand < nibble_t'(NUM_REGS));

  // immediate and selects are harmless while no enable is up
  assign ctrl.imm     = operand;
  assign ctrl.out_sel = reg_sel_t'(operand[1:0]);

  always_comb begin
    ctrl.lo_we  = '0;
    ctrl.hi_we  = '0;
    ctrl.alu_we = 1'b0;
    ctrl.alu_op = ALU_ADD;
    ctrl.in_we  = '0;
    ctrl.out_we = 1'b0;

    if (instr_valid) begin
      case (opcode)
        LDA_LO: ctrl.lo_we[REG_A] = 1'b1;
        LDA_HI: ctrl.hi_we[REG_A] = 1'b1;
        LDB_LO: ctrl.lo_we[REG_B] = 1'b1;
        LDB_HI: ctrl.hi_we[REG_B] = 1'b1;
        LDC_LO: ctrl.lo_we[REG_C] = 1'b1;
        LDC_HI: ctrl.hi_we[REG_C] = 1'b1;
        ADD: begin
          ctrl.alu_we = 1'b1;
          ctrl.alu_op = ALU_ADD;
        end
        SUB: begin
          ctrl.alu_we = 1'b1;
          ctrl.alu_op = ALU_SUB;
        end
        MUL: begin
          ctrl.alu_we = 1'b1;
          ctrl.alu_op = ALU_MUL;
        end
        IN: begin
          if (operand_is_reg) begin
            ctrl.in_we[operand[1:0]] = 1'b1;
          end
        end
        OUT: begin
          ctrl.out_we = operand_is_reg;
        end
        // NOP and the unused codes 12 to 15 leave everything idle
        default: ;
      endcase
    end
  end

  // one instruction drives one kind of write, never two at once
  always_comb begin
    a_one_group : assert final (
      $countones({|ctrl.lo_we, |ctrl.hi_we, ctrl.alu_we, |ctrl.in_we, ctrl.out_we}) <= 1
    ) else $error("instruction_decoder: more than one enable group active");
  end

endmodule

/* hw/cpu_datapath.sv */
//////////////////////////////////////////////////////////////////////
// cpu datapath
// registers A, B and C, the ALU writing into C, and the output
// register behind uo_out
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module cpu_datapath
  import cpu_pkg::*;
(
  input  logic          clk,
  input  logic          rst,
  cpu_ctrl_if.datapath  ctrl,
  input  data_t         in_data,
  output data_t         out_data
);

  data_t regs [NUM_REGS];
  data_t alu_result;
  data_t out_mux;

  //////////////////////////////////////////////////////////////////////
  // ALU
  //////////////////////////////////////////////////////////////////////

  // all three results are kept modulo 256
  always_comb begin
    case (ctrl.alu_op)
      ALU_ADD: alu_result = regs[REG_A] + regs[REG_B];
      ALU_SUB: alu_result = regs[REG_A] - regs[REG_B];
      ALU_MUL: alu_result = regs[REG_A] * regs[REG_B];
      default: alu_result = '0;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // register file
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else begin
      for (int i = 0; i < NUM_REGS; i++) begin
        if (ctrl.in_we[i]) begin
          regs[i] <= in_data;
        end else begin
          // a nibble load leaves the other half alone
          if (ctrl.lo_we[i]) begin
            regs[i][3:0] <= ctrl.imm;
          end
          if (ctrl.hi_we[i]) begin
            regs[i][7:4] <= ctrl.imm;
          end
        end
      end
      if (ctrl.alu_we) begin
        regs[REG_C] <= alu_result;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // output register
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (ctrl.out_sel)
      REG_A:   out_mux = regs[REG_A];
      REG_B:   out_mux = regs[REG_B];
      REG_C:   out_mux = regs[REG_C];
      default: out_mux = '0;
    endcase
  end

  // holds the last OUT value until the next OUT
  always_ff @(posedge clk) begin
    if (rst) begin
      out_data <= '0;
    end else if (ctrl.out_we) begin
      out_data <= out_mux;
    end
  end

  // decoder filters operands 3..15 out of OUT
  a_out_sel_valid : assert property (
    @(posedge clk) disable iff (rst)
      ctrl.out_we |-> (ctrl.out_sel != REG_NONE)
  ) else $error("cpu_datapath: OUT with no register selected");

endmodule

/* hw/cpu_top.sv */
//////////////////////////////////////////////////////////////////////
// cpu top level
// splits the control pins into run, mode and address and wires the
// program store, decoder and datapath
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module cpu_top
  import cpu_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  data_t ui_in,
  input  data_t uio_in,
  output data_t uo_out
);

  logic  run;
  logic  load_we;
  addr_t load_addr;
  data_t instr;
  logic  instr_valid;

  // control pin fields
  assign run       = uio_in[RUN_BIT];
  assign load_we   = (uio_in[MODE_MSB:MODE_LSB] == MODE_LOAD);
  assign load_addr = uio_in[ADDR_MSB:ADDR_LSB];

  cpu_ctrl_if ctrl_if ();

  program_store u_program_store (
    .clk         (clk),
    .rst         (rst),
    .run         (run),
    .load_we     (load_we),
    .load_addr   (load_addr),
    .load_data   (ui_in),
    .instr       (instr),
    .instr_valid (instr_valid)
  );

  instruction_decoder u_instruction_decoder (
    .instr       (instr),
    .instr_valid (instr_valid),
    .ctrl        (ctrl_if.decoder)
  );

  // ui_in doubles as the IN source while running
  cpu_datapath u_cpu_datapath (
    .clk      (clk),
    .rst      (rst),
    .ctrl     (ctrl_if.datapath),
    .in_data  (ui_in),
    .out_data (uo_out)
  );

endmodule

/* bench/cpu_model.svh */
//////////////////////////////////////////////////////////////////////
// cpu reference model
// program memory, registers and output byte, stepped once per edge
//////////////////////////////////////////////////////////////////////

`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH

data_t m_mem [MEM_DEPTH];
data_t m_regs [3];
data_t m_out;
int    m_pc;
logic  m_valid;

task automatic model_reset();
  for (int i = 0; i < MEM_DEPTH; i++) begin
    m_mem[i] = 8'h00;
  end
  for (int r = 0; r < 3; r++) begin
    m_regs[r] = 8'h00;
  end
  m_out   = 8'h00;
  m_pc    = 0;
  m_valid = 1'b0;
endtask

// ctl and din are the pin values seen at this rising edge
task automatic model_edge(input data_t ctl, input data_t din);
  data_t instr;
  int    code;
  int    arg;
  if (m_valid) begin
    instr = m_mem[m_pc];
    code  = int'(instr[7:4]);
    arg   = int'(instr[3:0]);
    case (code)
      1: m_regs[0][3:0] = instr[3:0];
      2: m_regs[0][7:4] = instr[3:0];
      3: m_regs[1][3:0] = instr[3:0];
      4: m_regs[1][7:4] = instr[3:0];
      5: m_regs[2][3:0] = instr[3:0];
      6: m_regs[2][7:4] = instr[3:0];
      7: m_regs[2] = data_t'((int'(m_regs[0]) + int'(m_regs[1])) % 256);
      8: m_regs[2] = data_t'((int'(m_regs[0]) - int'(m_regs[1]) + 256) % 256);
      9: m_regs[2] = data_t'((int'(m_regs[0]) * int'(m_regs[1])) % 256);
      10: begin
        if (arg < 3) m_out = m_regs[arg];
      end
      11: begin
        if (arg < 3) m_regs[arg] = din;
      end
      // 0 and 12..15 do nothing
      default: ;
    endcase
    m_pc = (m_pc + 1) % MEM_DEPTH;
  end else begin
    m_pc = 0;
  end
  // host write lands at the same edge, fetch above used the old byte
  if (ctl[5:4] == 2'b01) begin
    m_mem[int'(ctl[3:0])] = din;
  end
  m_valid = ctl[7];
endtask

`endif

/* bench/cpu_tb.sv */
//////////////////////////////////////////////////////////////////////
// cpu testbench
// random programs against a reference model of the processor
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module cpu_tb
  import cpu_pkg::*;
();

  localparam int CLK_PERIOD    = 40;
  localparam int RESET_CYCLES  = 8;
  localparam int IDLE_CYCLES   = 40;
  localparam int SHORT_RUN     = 14;
  localparam int LONG_RUN      = 64;
  localparam int RANDOM_PROGS  = 4;
  localparam int STOP_CYCLES   = 2;
  localparam int PROG_CYCLES   = MEM_DEPTH + STOP_CYCLES;
  localparam int TOTAL_CYCLES  = RESET_CYCLES + IDLE_CYCLES + 3 * (PROG_CYCLES + SHORT_RUN)
                               + RANDOM_PROGS * (PROG_CYCLES + LONG_RUN);
  localparam int MARGIN_CYCLES = 20;

  logic        clk;
  logic        rst;
  data_t       ui_in;
  data_t       uio_in;
  data_t       uo_out;
  logic [31:0] rng_state;
  int          checks;
  int          errors;
  int          tests_run;
  int          tests_failed;
  data_t       prog [MEM_DEPTH];
  // uo_out after, and ui_in at, each edge of the last run
  data_t       run_out [LONG_RUN];
  data_t       run_din [LONG_RUN];

  `include "cpu_model.svh"

  cpu_top dut0 (
    .clk    (clk),
    .rst    (rst),
    .ui_in  (ui_in),
    .uio_in (uio_in),
    .uo_out (uo_out)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic data_t rand_byte();
    rng_state = xorshift32(rng_state);
    return rng_state[15:8];
  endfunction

  function automatic data_t encode(input opcode_e code, input nibble_t arg);
    return {code, arg};
  endfunction

  task automatic check_value(input data_t got, input data_t expected, input string what);
    checks++;
    assert (got === expected) else begin
      errors++;
      $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, what, got, expected);
    end
  endtask

  // called 2 ns after an edge, returns 2 ns after the next one
  task automatic apply_cycle(input data_t ctl, input data_t din);
    uio_in = ctl;
    ui_in  = din;
    @(posedge clk);
    model_edge(ctl, din);
    #2;
    check_value(uo_out, m_out, "uo_out against model");
  endtask

  task automatic load_program();
    for (int a = 0; a < MEM_DEPTH; a++) begin
      apply_cycle({2'b00, MODE_LOAD, addr_t'(a)}, prog[a]);
    end
  endtask

  task automatic run_program(input int run_cycles);
    data_t din;
    for (int i = 0; i < run_cycles; i++) begin
      din = rand_byte();
      run_din[i] = din;
      apply_cycle(8'h80, din);
      run_out[i] = uo_out;
    end
    repeat (STOP_CYCLES) apply_cycle(8'h00, rand_byte());
  endtask

  task automatic finish_test(input string name, input int err_before);
    tests_run++;
    if (errors == err_before) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", tests_run, name, errors - err_before);
    end
  endtask

  initial begin
    int    err_before;
    data_t a;
    data_t b;
    data_t c;
    data_t rb;
    clk          = 1'b0;
    rst          = 1'b1;
    ui_in        = 8'h00;
    uio_in       = 8'h00;
    rng_state    = 32'hefa2_ea16;
    checks       = 0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    model_reset();
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    rst = 1'b0;

    // stopped, random control bytes with run low, some of them loads
    err_before = errors;
    check_value(uo_out, 8'h00, "uo_out after reset");
    for (int i = 0; i < IDLE_CYCLES; i++) begin
      rb = rand_byte();
      apply_cycle({1'b0, rb[6:0]}, rand_byte());
      check_value(uo_out, 8'h00, "uo_out while stopped");
    end
    finish_test("stopped and loading", err_before);

    // addr k executes at run edge k+1
    err_before = errors;
    a = rand_byte();
    b = rand_byte();
    c = rand_byte();
    prog = '{default: 8'h00};
    prog[0] = encode(LDA_LO, a[3:0]);
    prog[1] = encode(LDA_HI, a[7:4]);
    prog[2] = encode(LDB_LO, b[3:0]);
    prog[3] = encode(LDB_HI, b[7:4]);
    prog[4] = encode(LDC_LO, c[3:0]);
    prog[5] = encode(LDC_HI, c[7:4]);
    prog[6] = encode(OUT, 4'd0);
    prog[7] = encode(OUT, 4'd1);
    prog[8] = encode(OUT, 4'd2);
    load_program();
    run_program(SHORT_RUN);
    check_value(run_out[7], a, "OUT A");
    check_value(run_out[8], b, "OUT B");
    check_value(run_out[9], c, "OUT C");
    finish_test("nibble loads", err_before);

    err_before = errors;
    a = rand_byte();
    b = rand_byte();
    prog = '{default: 8'h00};
    prog[0] = encode(LDA_LO, a[3:0]);
    prog[1] = encode(LDA_HI, a[7:4]);
    prog[2] = encode(LDB_LO, b[3:0]);
    prog[3] = encode(LDB_HI, b[7:4]);
    prog[4] = encode(ADD, 4'd0);
    prog[5] = encode(OUT, 4'd2);
    prog[6] = encode(SUB, 4'd0);
    prog[7] = encode(OUT, 4'd2);
    prog[8] = encode(MUL, 4'd0);
    prog[9] = encode(OUT, 4'd2);
    load_program();
    run_program(SHORT_RUN);
    check_value(run_out[6], data_t'((int'(a) + int'(b)) % 256), "ADD");
    check_value(run_out[8], data_t'((int'(a) - int'(b) + 256) % 256), "SUB");
    check_value(run_out[10], data_t'((int'(a) * int'(b)) % 256), "MUL");
    finish_test("arithmetic", err_before);

    err_before = errors;
    prog = '{default: 8'h00};
    for (int r = 0; r < 3; r++) begin
      prog[2 * r]     = encode(IN, nibble_t'(r));
      prog[2 * r + 1] = encode(OUT, nibble_t'(r));
    end
    load_program();
    run_program(SHORT_RUN);
    for (int r = 0; r < 3; r++) begin
      check_value(run_out[2 * r + 2], run_din[2 * r + 1], "IN then OUT");
    end
    finish_test("input capture", err_before);

    // whole byte range, unused codes and out of range operands included
    err_before = errors;
    for (int p = 0; p < RANDOM_PROGS; p++) begin
      for (int i = 0; i < MEM_DEPTH; i++) begin
        prog[i] = rand_byte();
      end
      load_program();
      run_program(LONG_RUN);
    end
    finish_test("random programs", err_before);

    $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    #((TOTAL_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
    $display("timeout: tests did not finish within %0d cycles", TOTAL_CYCLES + MARGIN_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

endmodule

/* list.f */
+incdir+bench
hw/cpu_pkg.sv
hw/cpu_ctrl_if.sv
hw/program_store.sv
hw/instruction_decoder.sv
hw/cpu_datapath.sv
hw/cpu_top.sv
bench/cpu_tb.sv

/* Makefile */
# Verilator build and run of the cpu testbench

TOP = cpu_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, pass if TEST PASSED is printed"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -Mdir obj_dir -o sim
	./obj_dir/sim | tee /dev/stderr | grep "TEST PASSED" > /dev/null

clean:
	rm -rf obj_dir
